// ==== hdl/mcd_config.svh ====
`ifndef MCD_CONFIG_SVH
`define MCD_CONFIG_SVH

// CPU memory map, byte addresses on the 23 bit bus
`define MCD_RAM_LAST        23'h3fffff
`define MCD_ROM_FIRST       23'h400000
`define MCD_ROM_LAST        23'h4ffbff
`define MCD_SYSIO_FIRST     23'h4ffc00
`define MCD_CH2_FIRST       23'h4fffe0
`define MCD_CH1_FIRST       23'h4ffff0

// Upper byte accesses after reset that go to ROM
`define MCD_BOOT_ACCESSES   3'd4
// SDRAM address bits 24:22 of the ROM image
`define MCD_ROM_PREFIX      3'b001

// Display timing, shrunk for simulation
`define MCD_LINE_CLOCKS     64
`define MCD_FRAME_LINES     12
`define MCD_ACTIVE_LINES    8
`define MCD_HSYNC_CLOCKS    6
`define MCD_REFRESH_CLOCKS  8

// SDRAM word address of the first video word
`define MCD_VIDEO_BASE      24'h010000

`endif

// ==== hdl/mcd_pkg.sv ====
`default_nettype none

package mcd_pkg;

    // CPU bus as seen by the controller
    typedef struct packed {
        logic [22:1] address;
        logic [15:0] din;
        logic        uds;
        logic        lds;
        logic        write_strobe;
        logic        cs;
    } cpu_req_t;

    // Command towards the SDRAM controller
    typedef struct packed {
        logic [24:0] addr;
        logic        rd;
        logic        wr;
        logic        word;
        logic [15:0] din;
        logic        refresh;
    } sdram_cmd_t;

    // Listed from highest to lowest priority
    typedef enum logic [1:0] {
        REFRESH,
        VIDEO,
        CPU
    } sdram_owner_e;

    // CPU access after address decoding, handed to the arbiter
    typedef struct packed {
        logic        active;
        logic        rd;
        logic        wr;
        logic        word;
        logic [24:0] addr;
        logic [15:0] din;
    } cpu_mem_req_t;

    typedef struct packed {
        logic       de;
        logic       cf;
        logic       fd;
        logic       sm;
        logic       cm1;
        logic       reserved1;
        logic       ic1;
        logic       dc1;
        logic [1:0] reserved2;
        logic [5:0] adr;
    } dcr1_fields_t;

    // Display command register 1, written as a word, read as fields
    typedef union packed {
        logic [15:0]  raw;
        dcr1_fields_t f;
    } dcr1_u;

endpackage

`default_nettype wire

// ==== hdl/cpu_bus_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mcd_config.svh"

module cpu_bus_decoder
    import mcd_pkg::*;
(
    input  wire cpu_req_t     cpu,
    input  wire               clk,
    input  wire               reset,
    input  wire        [15:0] sdram_dout,
    input  wire               cpu_grant_ack,
    input  wire               vblank,
    input  wire               new_frame,
    output cpu_mem_req_t      mem_req,
    output logic       [15:0] cpu_dout,
    output logic              cpu_bus_ack,
    output logic              video_enable
);

    logic [22:0] byte_addr;
    logic [2:0]  boot_cnt;
    logic        boot_rom;
    logic        cs_ram;
    logic        cs_rom;
    logic        cs_io;
    logic        cs_chan;
    logic        cs_ch1;
    logic        sdram_access;
    logic        reg_write;
    logic [19:1] ram_addr;
    dcr1_u       dcr1;
    logic        parity;

    assign byte_addr = {cpu.address, 1'b0};

    // Boot overlay: every selected access is ROM until the count is reached
    assign boot_rom = boot_cnt < `MCD_BOOT_ACCESSES;

    assign cs_ram  = cpu.cs && !boot_rom && byte_addr <= `MCD_RAM_LAST;
    assign cs_rom  = cpu.cs && (boot_rom ||
                     (byte_addr >= `MCD_ROM_FIRST && byte_addr <= `MCD_ROM_LAST));
    // I/O ends at the top of the 0x4xxxxx region
    assign cs_io   = cpu.cs && !boot_rom && byte_addr >= `MCD_SYSIO_FIRST &&
                     byte_addr[22:20] == 3'h4;
    assign cs_chan = cs_io && byte_addr >= `MCD_CH2_FIRST;
    assign cs_ch1  = cs_chan && byte_addr >= `MCD_CH1_FIRST;

    assign sdram_access = (cs_ram || cs_rom) && (cpu.uds || cpu.lds);
    assign reg_write    = cs_ch1 && cpu.write_strobe && (cpu.uds || cpu.lds);

    // Bank bit 18 moves below bit 21
    assign ram_addr = {cpu.address[21], cpu.address[18], cpu.address[17:1]};

    always_comb begin
        mem_req        = '0;
        mem_req.active = sdram_access;
        mem_req.din    = cpu.din;
        if (sdram_access) begin
            if (cs_rom) begin
                // ROM writes turn into a dummy read so they still complete
                mem_req.addr = {`MCD_ROM_PREFIX, cpu.address[21:1], 1'b0};
                mem_req.word = 1'b1;
                mem_req.rd   = 1'b1;
            end else begin
                mem_req.addr = {5'b0, ram_addr,
                                cpu.write_strobe && cpu.uds && !cpu.lds};
                mem_req.word = (cpu.uds && cpu.lds) || !cpu.write_strobe;
                mem_req.rd   = !cpu.write_strobe;
                mem_req.wr   = cpu.write_strobe;
            end
        end
    end

    assign cpu_bus_ack = sdram_access ? cpu_grant_ack : 1'b1;

    always_comb begin
        cpu_dout = 16'h0;
        if (cs_ram || cs_rom) begin
            cpu_dout = sdram_dout;
        end else if (cs_ch1 && byte_addr[3:0] == 4'h0) begin
            // Status register
            cpu_dout = {8'h0, !vblank, 1'b0, parity, 5'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            boot_cnt <= '0;
            dcr1     <= '0;
            parity   <= 1'b0;
        end else begin
            if (cpu.cs && cpu.uds && boot_rom && cpu_bus_ack) begin
                boot_cnt <= boot_cnt + 3'd1;
            end
            if (reg_write && byte_addr[3:0] == 4'h2) begin
                dcr1.raw <= cpu.din;
            end
            if (new_frame) begin
                parity <= !parity;
            end
        end
    end

    assign video_enable = dcr1.f.ic1;

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_req.rd && mem_req.wr))
        else $error("CPU memory request with rd and wr together");

endmodule

`default_nettype wire

// ==== hdl/sdram_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module sdram_arbiter
    import mcd_pkg::*;
(
    input  wire               clk,
    input  wire               reset,
    input  wire               refresh_req,
    input  wire               video_req,
    input  wire        [24:1] video_addr,
    input  wire cpu_mem_req_t mem_req,
    input  wire        [15:0] sdram_dout,
    input  wire               sdram_busy,
    output sdram_cmd_t        sdram,
    output logic              cpu_grant_ack,
    output logic              video_ack
);

    sdram_owner_e owner;
    sdram_owner_e owner_q;
    sdram_owner_e owner_next;
    logic         busy_q;
    logic         port_free;
    logic         done;

    // Fixed priority, later assignments win
    always_comb begin
        owner_next = CPU;
        if (video_req) begin
            owner_next = VIDEO;
        end
        if (refresh_req) begin
            owner_next = REFRESH;
        end
    end

    // Ownership may only move while the SDRAM is idle
    assign owner = sdram_busy ? owner_q : owner_next;

    // A new access waits until the previous one has fully finished
    assign port_free = !sdram_busy && !busy_q;
    // Falling edge of busy marks completion
    assign done = !sdram_busy && busy_q;

    always_comb begin
        sdram     = '0;
        // Only the CPU ever writes
        sdram.din = mem_req.din;
        case (owner)
            REFRESH: begin
                // Repeated reads of the same row keep auto refresh going
                sdram.refresh = 1'b1;
                sdram.rd      = !sdram_busy;
            end
            VIDEO: begin
                sdram.addr = {video_addr, 1'b0};
                sdram.word = 1'b1;
                sdram.rd   = video_req && port_free;
            end
            CPU: begin
                if (mem_req.active) begin
                    sdram.addr = mem_req.addr;
                    sdram.word = mem_req.word;
                    sdram.rd   = mem_req.rd && port_free;
                    sdram.wr   = mem_req.wr && port_free;
                end
            end
            default: begin
            end
        endcase
    end

    // Completion belongs to whoever owned the port in the previous cycle
    always_comb begin
        cpu_grant_ack = 1'b0;
        video_ack     = 1'b0;
        case (owner_q)
            CPU: begin
                cpu_grant_ack = mem_req.active && done;
            end
            VIDEO: begin
                video_ack = video_req && done;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            owner_q <= CPU;
            busy_q  <= 1'b0;
        end else begin
            owner_q <= owner;
            busy_q  <= sdram_busy;
        end
    end

    // Read data is only meaningful at completion; an owner switch there would lose it
    owner_frozen: assert property (@(posedge clk) disable iff (reset)
        sdram_busy |-> owner == $past(owner))
        else $error("SDRAM owner changed during a busy window");

    // Every command must open a busy window in the next cycle
    cmd_accepted: assert property (@(posedge clk) disable iff (reset)
        (sdram.rd || sdram.wr) |=> sdram_busy)
        else $error("SDRAM ignored a command");

endmodule

`default_nettype wire

// ==== hdl/display_timing.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mcd_config.svh"

module display_timing (
    input  wire  clk,
    input  wire  reset,
    output logic hsync,
    output logic vsync,
    output logic vblank,
    output logic new_frame,
    output logic refresh_req
);

    localparam int PIXEL_W = $clog2(`MCD_LINE_CLOCKS);
    localparam int LINE_W  = $clog2(`MCD_FRAME_LINES);

    logic [PIXEL_W-1:0] pixel;
    logic [PIXEL_W-1:0] pixel_next;
    logic [LINE_W-1:0]  line;
    logic               line_end;
    logic               frame_end;

    assign line_end   = pixel == PIXEL_W'(`MCD_LINE_CLOCKS - 1);
    assign frame_end  = line_end && line == LINE_W'(`MCD_FRAME_LINES - 1);
    assign pixel_next = line_end ? '0 : pixel + 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            pixel       <= '0;
            line        <= '0;
            new_frame   <= 1'b0;
            refresh_req <= 1'b0;
        end else begin
            pixel       <= pixel_next;
            if (frame_end) begin
                line <= '0;
            end else if (line_end) begin
                line <= line + 1'b1;
            end
            // Pulse in the cycle the counters sit at line 0, pixel 0
            new_frame   <= frame_end;
            // Refresh window at the start of every line
            refresh_req <= pixel_next < PIXEL_W'(`MCD_REFRESH_CLOCKS);
        end
    end

    assign hsync  = pixel < PIXEL_W'(`MCD_HSYNC_CLOCKS);
    assign vblank = line >= LINE_W'(`MCD_ACTIVE_LINES);
    assign vsync  = line == LINE_W'(`MCD_FRAME_LINES - 1);

endmodule

`default_nettype wire

// ==== hdl/video_fetcher.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mcd_config.svh"

module video_fetcher (
    input  wire         clk,
    input  wire         reset,
    input  wire         enable,
    input  wire         vblank,
    input  wire         new_frame,
    input  wire         ack,
    input  wire  [15:0] sdram_dout,
    output logic        req,
    output logic [24:1] addr,
    output logic [15:0] pixel_word,
    output logic        pixel_valid
);

    logic pending;
    logic fetch_ok;

    // Request raised but not yet served
    assign pending  = req && !ack;
    assign fetch_ok = enable && !vblank;

    always_ff @(posedge clk) begin
        if (reset) begin
            req  <= 1'b0;
            addr <= `MCD_VIDEO_BASE;
        end else begin
            // An outstanding request survives the start of vblank
            req <= pending || fetch_ok;
            if (new_frame) begin
                addr <= `MCD_VIDEO_BASE;
            end else if (ack) begin
                addr <= addr + 24'd1;
            end
        end
    end

    // One word per acknowledge, straight from the SDRAM
    assign pixel_valid = ack;
    assign pixel_word  = ack ? sdram_dout : 16'h0;

    // Also catches a frame restart racing an unfinished fetch
    addr_stable: assert property (@(posedge clk) disable iff (reset)
        pending |=> $stable(addr))
        else $error("Video address moved under a pending request");

    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        ack |-> req)
        else $error("Video acknowledge without request");

endmodule

`default_nettype wire

// ==== hdl/mcd_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mcd_top
    import mcd_pkg::*;
(
    input  wire               clk,
    input  wire               reset,
    input  wire cpu_req_t     cpu,
    input  wire        [15:0] sdram_dout,
    input  wire               sdram_busy,
    output wire        [15:0] cpu_dout,
    output wire               cpu_bus_ack,
    output wire sdram_cmd_t   sdram,
    output wire               hsync,
    output wire               vsync,
    output wire               vblank,
    output wire        [15:0] pixel_word,
    output wire               pixel_valid
);

    cpu_mem_req_t mem_req;
    logic         cpu_grant_ack;
    logic         video_req;
    logic [24:1]  video_addr;
    logic         video_ack;
    logic         video_enable;
    logic         refresh_req;
    logic         new_frame;

    cpu_bus_decoder decoder0 (
        .clk,
        .reset,
        .cpu,
        .sdram_dout,
        .cpu_grant_ack,
        .vblank,
        .new_frame,
        .mem_req,
        .cpu_dout,
        .cpu_bus_ack,
        .video_enable
    );

    sdram_arbiter arbiter0 (
        .clk,
        .reset,
        .refresh_req,
        .video_req,
        .video_addr,
        .mem_req,
        .sdram_dout,
        .sdram_busy,
        .sdram,
        .cpu_grant_ack,
        .video_ack
    );

    display_timing timing0 (
        .clk,
        .reset,
        .hsync,
        .vsync,
        .vblank,
        .new_frame,
        .refresh_req
    );

    video_fetcher fetcher0 (
        .clk,
        .reset,
        .enable      (video_enable),
        .vblank,
        .new_frame,
        .ack         (video_ack),
        .sdram_dout,
        .req         (video_req),
        .addr        (video_addr),
        .pixel_word,
        .pixel_valid
    );

endmodule

`default_nettype wire

// ==== test/sdram_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module sdram_model
    import mcd_pkg::*;
(
    input  wire               clk,
    input  wire               reset,
    input  wire sdram_cmd_t   cmd,
    output logic              busy,
    output logic       [15:0] dout
);

    logic [15:0] mem [int unsigned];
    int          remaining;

    // Contents of a word that was never written
    function automatic logic [15:0] fill_word(input logic [23:0] a);
        return a[15:0] ^ {a[23:16], a[23:16]} ^ 16'h5a3c;
    endfunction

    function automatic logic [15:0] read_word(input logic [23:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return fill_word(a);
    endfunction

    always @(posedge clk) begin
        logic [23:0] wa;
        logic [15:0] old;
        wa  = cmd.addr[24:1];
        old = read_word(wa);
        if (reset) begin
            busy      <= 1'b0;
            dout      <= 16'h0;
            remaining <= 0;
        end else if (busy) begin
            if (remaining == 1) begin
                busy <= 1'b0;
            end
            remaining <= remaining - 1;
        end else if (cmd.rd || cmd.wr) begin
            busy      <= 1'b1;
            remaining <= $urandom_range(5, 2);
            if (cmd.wr) begin
                // Byte writes pick the lane with address bit 0
                if (cmd.word) begin
                    mem[wa] = cmd.din;
                end else if (cmd.addr[0]) begin
                    mem[wa] = {cmd.din[15:8], old[7:0]};
                end else begin
                    mem[wa] = {old[15:8], cmd.din[7:0]};
                end
            end else if (!cmd.refresh) begin
                dout <= old;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_mcd.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mcd_config.svh"

module tb_mcd
    import mcd_pkg::*;
();

    localparam int PERIOD       = 40;
    localparam int FRAME_CLOCKS = `MCD_LINE_CLOCKS * `MCD_FRAME_LINES;
    localparam int WORST_CLOCKS = FRAME_CLOCKS + 16;
    localparam int NUM_OPS      = 150;
    localparam int TOTAL_ACCESS = 2 * NUM_OPS + 8;

    logic        clk;
    logic        reset;
    cpu_req_t    cpu;
    logic [15:0] sdram_dout;
    logic        sdram_busy;
    logic [15:0] cpu_dout;
    logic        cpu_bus_ack;
    sdram_cmd_t  sdram;
    logic        hsync;
    logic        vsync;
    logic        vblank;
    logic [15:0] pixel_word;
    logic        pixel_valid;

    logic [15:0] ref_mem [int unsigned];
    int          errors;
    int          pix;
    int          line_no;
    int          frames;
    logic        wrap_seen;
    logic        video_on;
    logic [23:0] vid_ptr;
    logic [24:0] last_cmd_addr;
    int          boot_left;

    mcd_top dut0 (
        .clk,
        .reset,
        .cpu,
        .sdram_dout,
        .sdram_busy,
        .cpu_dout,
        .cpu_bus_ack,
        .sdram,
        .hsync,
        .vsync,
        .vblank,
        .pixel_word,
        .pixel_valid
    );

    sdram_model sdram0 (
        .clk,
        .reset,
        .cmd  (sdram),
        .busy (sdram_busy),
        .dout (sdram_dout)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    function automatic logic [15:0] preload_word(input logic [23:0] a);
        return a[15:0] ^ {a[23:16], a[23:16]} ^ 16'h5a3c;
    endfunction

    function automatic logic [15:0] ref_read(input logic [23:0] a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return preload_word(a);
    endfunction

    // RAM bank swap: bit 21, then bit 18, then bits 17:1
    function automatic logic [23:0] ram_word(input logic [22:1] a);
        return {5'b0, a[21], a[18], a[17:1]};
    endfunction

    function automatic logic [23:0] rom_word(input logic [22:1] a);
        return {3'b001, a[21:1]};
    endfunction

    function automatic logic [22:1] random_ram_addr();
        // A quarter of the accesses land on the first video words
        if ($urandom_range(3, 0) == 0) begin
            return {5'b0, 1'b1, 8'b0, 8'($urandom)};
        end
        return {1'b0, 21'($urandom)};
    endfunction

    // Reference display counters, aligned with the DUT after reset
    always @(posedge clk) begin
        if (reset) begin
            pix       <= 0;
            line_no   <= 0;
            frames    <= 0;
            wrap_seen <= 1'b0;
        end else begin
            if (wrap_seen) begin
                frames <= frames + 1;
            end
            wrap_seen <= pix == `MCD_LINE_CLOCKS - 1 && line_no == `MCD_FRAME_LINES - 1;
            if (pix == `MCD_LINE_CLOCKS - 1) begin
                pix     <= 0;
                line_no <= (line_no == `MCD_FRAME_LINES - 1) ? 0 : line_no + 1;
            end else begin
                pix <= pix + 1;
            end
        end
    end

    // SDRAM port and video monitor
    always @(negedge clk) begin
        if (!reset) begin
            // Sync and blanking against the reference counters
            compare("hsync", hsync, pix < `MCD_HSYNC_CLOCKS);
            compare("vsync", vsync, line_no == `MCD_FRAME_LINES - 1);
            compare("vblank", vblank, line_no >= `MCD_ACTIVE_LINES);
            if ((sdram.rd || sdram.wr) && sdram_busy) begin
                $display("SDRAM command issued while the SDRAM was busy");
                errors++;
            end
            if ((sdram.rd || sdram.wr) && pix < `MCD_REFRESH_CLOCKS) begin
                compare("sdram.refresh", sdram.refresh, 1'b1);
            end
            if (sdram.wr) begin
                compare("sdram.addr[24:20]", sdram.addr[24:20], 5'b0);
            end
            if ((sdram.rd || sdram.wr) && !sdram.refresh) begin
                last_cmd_addr = sdram.addr;
            end
            if (pix == 0 && line_no == 0) begin
                vid_ptr = `MCD_VIDEO_BASE;
            end
            if (pixel_valid) begin
                if (!video_on) begin
                    $display("Video word delivered while video was disabled");
                    errors++;
                end
                compare("pixel_word", pixel_word, ref_read(vid_ptr));
                vid_ptr = vid_ptr + 24'd1;
            end
        end
    end

    task automatic cpu_access(input logic [22:1] address, input logic write,
                              input logic uds, input logic lds, input logic [15:0] din,
                              output logic [15:0] rdata, output logic [15:0] status);
        int waited;
        waited = 0;
        @(posedge clk);
        cpu <= '{address: address, din: din, uds: uds, lds: lds,
                 write_strobe: write, cs: 1'b1};
        @(negedge clk);
        while (!cpu_bus_ack && waited < WORST_CLOCKS) begin
            @(negedge clk);
            waited++;
        end
        if (!cpu_bus_ack) begin
            $display("CPU access at byte address %h was never acknowledged",
                     {address, 1'b0});
            errors++;
        end
        rdata  = cpu_dout;
        status = {8'h0, line_no < `MCD_ACTIVE_LINES, 1'b0, frames[0], 5'b0};
        @(posedge clk);
        cpu <= '0;
    endtask

    task automatic read_check(input logic [22:1] address, input logic uds, input logic lds);
        logic [15:0] rdata;
        logic [15:0] status;
        logic [15:0] expected;
        logic [22:0] byte_addr;
        logic        boot;
        byte_addr = {address, 1'b0};
        boot      = boot_left > 0;
        cpu_access(address, 1'b0, uds, lds, 16'h0, rdata, status);
        if (boot) begin
            expected = ref_read(rom_word(address));
            compare("sdram.addr[24:22]", last_cmd_addr[24:22], 3'b001);
        end else if (byte_addr <= `MCD_RAM_LAST) begin
            expected = ref_read(ram_word(address));
        end else if (byte_addr <= `MCD_ROM_LAST) begin
            expected = ref_read(rom_word(address));
        end else if (byte_addr == `MCD_CH1_FIRST) begin
            expected = status;
        end else begin
            expected = 16'h0;
        end
        if (boot && uds) begin
            boot_left--;
        end
        compare("cpu_dout", rdata, expected);
    endtask

    task automatic write_op(input logic [22:1] address, input logic uds, input logic lds,
                            input logic [15:0] din);
        logic [15:0] rdata;
        logic [15:0] status;
        logic [15:0] old;
        logic [23:0] idx;
        cpu_access(address, 1'b1, uds, lds, din, rdata, status);
        if ({address, 1'b0} <= `MCD_RAM_LAST) begin
            idx = ram_word(address);
            old = ref_read(idx);
            if (uds && lds) begin
                ref_mem[idx] = din;
            end else if (uds) begin
                ref_mem[idx] = {din[15:8], old[7:0]};
            end else begin
                ref_mem[idx] = {old[15:8], din[7:0]};
            end
        end
    endtask

    initial begin
        logic [22:1] written[$];
        logic [22:1] addr;
        logic [1:0]  strobes;
        int          kind;
        void'($urandom(72392));
        errors    = 0;
        video_on  = 1'b0;
        boot_left = `MCD_BOOT_ACCESSES;
        vid_ptr   = `MCD_VIDEO_BASE;
        cpu   <= '0;
        reset <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // Boot overlay reads at arbitrary addresses
        repeat (`MCD_BOOT_ACCESSES) begin
            read_check(22'($urandom), 1'b1, 1'($urandom));
        end

        // A full frame with video still disabled
        repeat (FRAME_CLOCKS) @(posedge clk);

        // DCR1 with ic1 set
        write_op(22'h27fff9, 1'b1, 1'b1, 16'h0200);
        video_on = 1'b1;

        for (int i = 0; i < NUM_OPS; i++) begin
            kind = $urandom_range(9, 0);
            if (kind <= 2) begin
                addr    = random_ram_addr();
                strobes = 2'($urandom_range(3, 1));
                write_op(addr, strobes[1], strobes[0], 16'($urandom));
                written.push_back(addr);
            end else if (kind <= 5) begin
                if (written.size() > 0 && $urandom_range(1, 0) == 1) begin
                    addr = written[$urandom_range(written.size() - 1, 0)];
                end else begin
                    addr = random_ram_addr();
                end
                read_check(addr, 1'b1, 1'b1);
            end else if (kind == 6) begin
                addr = {1'b1, 21'($urandom_range(21'h7fdff, 0))};
                write_op(addr, 1'b1, 1'b1, 16'($urandom));
                read_check(addr, 1'b1, 1'b1);
            end else if (kind == 7) begin
                read_check({1'b1, 21'($urandom_range(21'h7fdff, 0))}, 1'b1, 1'b1);
            end else if (kind == 8) begin
                read_check(22'h27fff8, 1'b1, 1'b1);
            end else begin
                read_check(22'h27fe00 + 22'($urandom_range(9'h1f7, 0)), 1'b1, 1'b1);
            end
        end

        // Let the fetcher run over two more frames
        repeat (2 * FRAME_CLOCKS) @(posedge clk);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Every access may wait up to a frame behind video and refresh
    initial begin
        #((TOTAL_ACCESS * WORST_CLOCKS + 5 * FRAME_CLOCKS) * PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hdl
hdl/mcd_pkg.sv
hdl/cpu_bus_decoder.sv
hdl/sdram_arbiter.sv
hdl/display_timing.sv
hdl/video_fetcher.sv
hdl/mcd_top.sv
test/sdram_model.sv
test/tb_mcd.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_mcd \
    -Mdir obj_dir -o sim_mcd > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/sim_mcd > sim.log 2>&1
grep -qF "*** TEST PASSED ***" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
